//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = soc_ifc_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/soc_ifc_assert.sv
`include "soc_ifc_consts.svh"

module soc_ifc_assert (
    input logic                       clk,
    input logic                       cptra_rst_b,
    input logic                       psel_i,
    input logic                       penable_i,
    input logic                       pready_i,
    input logic                       pslverr_i,
    input logic [`SOC_IFC_DATA_W-1:0] prdata_i,
    input logic                       uc_rst_b_i,
    input soc_ifc_pkg::boot_state_e   boot_state_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Error response only in the completing cycle and with zero read data
    slverr_with_ready: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        pslverr_i |-> (pready_i && prdata_i == '0))
        else $error("pslverr_o high without pready_o or with nonzero read data");

    // Completion only after one wait state in the access phase
    ready_in_access: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        pready_i |-> (psel_i && penable_i && $past(psel_i && penable_i && !pready_i)))
        else $error("pready_o high outside the second access cycle");

    // Once released, the core stays out of reset
    uc_rst_no_fall: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        !$fell(uc_rst_b_i))
        else $error("cptra_uc_rst_b_o fell while reset was high");

    boot_done_sticky: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        (boot_state_i == soc_ifc_pkg::DONE) |=> (boot_state_i == soc_ifc_pkg::DONE))
        else $error("Boot FSM left DONE without a reset");

endmodule

bind soc_ifc_top soc_ifc_assert i_assert (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pready_i     (pready_o),
    .pslverr_i    (pslverr_o),
    .prdata_i     (prdata_o),
    .uc_rst_b_i   (cptra_uc_rst_b_o),
    .boot_state_i (boot_state)
);

//--- bench/soc_ifc_tb.sv
`include "soc_ifc_consts.svh"

module soc_ifc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Whole sequence needs well under 1000 cycles, so this leaves wide headroom
    localparam int CYCLE_LIMIT = 5000;
    localparam int MARGIN      = 8;
    localparam int T1_PER      = 40;
    localparam int C1_PER      = 30;
    localparam int C2_PER      = 20;
    localparam int FW          = `SOC_IFC_FUSE_WORDS;

    logic                       clk;
    logic                       cptra_rst_b;
    logic                       bootfsm_brkpoint_i;
    logic [`SOC_IFC_ADDR_W-1:0] paddr_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [`SOC_IFC_DATA_W-1:0] pwdata_i;
    logic [`SOC_IFC_DATA_W-1:0] prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;
    logic                       ready_for_fuses_o;
    logic                       cptra_uc_rst_b_o;
    logic [FW-1:0][31:0]        fuse_uds_o;
    logic                       nmi_intr_o;
    logic                       cptra_error_fatal_o;

    int   errors;
    int   cycles;
    int   seed;
    logic chk_en;

    // Shadow of the register map
    logic                sh_done;
    logic                sh_go;
    logic                sh_t1_en;
    logic                sh_t2_en;
    logic [1:0]          sh_flow;
    logic [1:0]          sh_wdt;
    logic [31:0]         sh_t1_per;
    logic [31:0]         sh_t2_per;
    logic [FW-1:0][31:0] sh_fuse;

    soc_ifc_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d with %0d errors", cycles, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic logic is_fuse(input int addr);
        return addr >= `SOC_IFC_FUSE_UDS_BASE && addr < `SOC_IFC_FUSE_UDS_BASE + 4 * FW
            && addr % 4 == 0;
    endfunction

    // Returns read data above the error flag
    function automatic logic [32:0] expected_rsp(input logic write, input int addr);
        logic [31:0] data;
        logic        err;
        data = '0;
        err  = 1'b0;
        if (write) begin
            err = (addr == `SOC_IFC_FLOW_STATUS);
        end else if (is_fuse(addr)) begin
            data = sh_fuse[(addr - `SOC_IFC_FUSE_UDS_BASE) / 4];
        end else begin
            case (addr)
                `SOC_IFC_FUSE_WR_DONE:  data = 32'(sh_done);
                `SOC_IFC_FLOW_STATUS:   data = 32'(sh_flow);
                `SOC_IFC_BOOTFSM_GO:    data = 32'(sh_go);
                `SOC_IFC_WDT_T1_EN:     data = 32'(sh_t1_en);
                `SOC_IFC_WDT_T2_EN:     data = 32'(sh_t2_en);
                `SOC_IFC_WDT_T1_PERIOD: data = sh_t1_per;
                `SOC_IFC_WDT_T2_PERIOD: data = sh_t2_per;
                `SOC_IFC_WDT_STATUS:    data = 32'(sh_wdt);
                `SOC_IFC_WDT_T1_CTRL, `SOC_IFC_WDT_T2_CTRL: data = '0;
                default:                err = 1'b1;
            endcase
        end
        return {data, err};
    endfunction

    task automatic model_write(input int addr, input logic [31:0] data);
        // Fuses lock once done is set
        if (is_fuse(addr) && !sh_done) begin
            sh_fuse[(addr - `SOC_IFC_FUSE_UDS_BASE) / 4] = data;
        end
        case (addr)
            `SOC_IFC_FUSE_WR_DONE:  sh_done = sh_done | data[0];
            `SOC_IFC_BOOTFSM_GO:    sh_go = data[0];
            `SOC_IFC_WDT_T1_EN:     sh_t1_en = data[0];
            `SOC_IFC_WDT_T2_EN:     sh_t2_en = data[0];
            `SOC_IFC_WDT_T1_PERIOD: sh_t1_per = data;
            `SOC_IFC_WDT_T2_PERIOD: sh_t2_per = data;
            `SOC_IFC_WDT_STATUS:    sh_wdt = sh_wdt & ~data[1:0];
            default: ;
        endcase
    endtask

    task automatic model_reset();
        sh_done   = 1'b0;
        sh_go     = 1'b0;
        sh_t1_en  = 1'b0;
        sh_t2_en  = 1'b0;
        sh_flow   = 2'b00;
        sh_wdt    = 2'b00;
        sh_t1_per = `SOC_IFC_WDT_PERIOD_RST;
        sh_t2_per = `SOC_IFC_WDT_PERIOD_RST;
        sh_fuse   = '0;
    endtask

    //////////////////////////////////////////////////
    // Checks and waits
    //////////////////////////////////////////////////
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic out_level(input int which);
        case (which)
            0:       return ready_for_fuses_o;
            1:       return cptra_uc_rst_b_o;
            default: return nmi_intr_o;
        endcase
    endfunction

    task automatic wait_level(input string name, input int which, input logic level,
                              input int limit);
        int n;
        n = 0;
        while (out_level(which) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (out_level(which) !== level) begin
            errors++;
            $display("%s did not go to %0b within %0d cycles", name, level, limit);
        end
    endtask

    // Completed transfers are compared against the reference model
    always @(negedge clk) begin : compare_rsp
        logic [32:0] exp;
        if (psel_i && penable_i && pready_o && chk_en) begin
            exp = expected_rsp(pwrite_i, int'(paddr_i));
            check_val("prdata_o", prdata_o, exp[32:1]);
            check_val("pslverr_o", 32'(pslverr_o), 32'(exp[0]));
        end
    end

    //////////////////////////////////////////////////
    // APB driver
    //////////////////////////////////////////////////
    task automatic apb_transfer(input logic write, input int addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = 12'(addr);
        pwdata_i  = wdata;
        @(posedge clk);
        #1;
        penable_i = 1'b1;
        do begin
            @(negedge clk);
        end while (!pready_o);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input int addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        model_write(addr, data);
    endtask

    task automatic apb_read(input int addr);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, '0, rdata, err);
    endtask

    // Reads status until a timeout flag shows, counting from start
    task automatic poll_status(input int bit_idx, input int start, input int limit,
                               input string what);
        logic [31:0] rdata;
        logic        err;
        rdata  = '0;
        chk_en = 1'b0;
        while (!rdata[bit_idx] && cycles - start <= limit) begin
            apb_transfer(1'b0, `SOC_IFC_WDT_STATUS, '0, rdata, err);
        end
        chk_en = 1'b1;
        if (!rdata[bit_idx]) begin
            errors++;
            $display("Watchdog %s not seen within %0d cycles", what, limit);
        end else begin
            sh_wdt[bit_idx] = 1'b1;
        end
    endtask

    task automatic apply_reset(input logic brk);
        @(posedge clk);
        #1;
        cptra_rst_b        = 1'b0;
        bootfsm_brkpoint_i = brk;
        model_reset();
        repeat (10) @(posedge clk);
        #1;
        check_val("ready_for_fuses_o", 32'(ready_for_fuses_o), 32'd0);
        check_val("cptra_uc_rst_b_o", 32'(cptra_uc_rst_b_o), 32'd0);
        check_val("nmi_intr_o", 32'(nmi_intr_o), 32'd0);
        check_val("cptra_error_fatal_o", 32'(cptra_error_fatal_o), 32'd0);
        check_val("pready_o", 32'(pready_o), 32'd0);
        check_val("pslverr_o", 32'(pslverr_o), 32'd0);
        cptra_rst_b = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin : main
        int t0;
        errors             = 0;
        cycles             = 0;
        seed               = 35482;
        chk_en             = 1'b1;
        cptra_rst_b        = 1'b0;
        bootfsm_brkpoint_i = 1'b0;
        paddr_i            = '0;
        psel_i             = 1'b0;
        penable_i          = 1'b0;
        pwrite_i           = 1'b0;
        pwdata_i           = '0;
        model_reset();

        apply_reset(1'b0);
        wait_level("ready_for_fuses_o", 0, 1'b1, MARGIN);
        sh_flow = 2'b01;
        apb_read(`SOC_IFC_FLOW_STATUS);

        // Fuse programming, then lock
        for (int i = 0; i < FW; i++) begin
            apb_write(`SOC_IFC_FUSE_UDS_BASE + 4 * i, $random(seed));
        end
        for (int i = 0; i < FW; i++) begin
            apb_read(`SOC_IFC_FUSE_UDS_BASE + 4 * i);
            check_val($sformatf("fuse_uds_o[%0d]", i), fuse_uds_o[i], sh_fuse[i]);
        end
        apb_write(`SOC_IFC_FUSE_WR_DONE, 32'h1);
        for (int i = 0; i < FW; i++) begin
            apb_write(`SOC_IFC_FUSE_UDS_BASE + 4 * i, ~sh_fuse[i]);
            apb_read(`SOC_IFC_FUSE_UDS_BASE + 4 * i);
            check_val($sformatf("fuse_uds_o[%0d]", i), fuse_uds_o[i], sh_fuse[i]);
        end
        apb_write(`SOC_IFC_FUSE_WR_DONE, 32'h0);
        apb_read(`SOC_IFC_FUSE_WR_DONE);

        // Release without breakpoint
        wait_level("cptra_uc_rst_b_o", 1, 1'b1, MARGIN);
        check_val("ready_for_fuses_o", 32'(ready_for_fuses_o), 32'd0);
        sh_flow = 2'b10;
        apb_read(`SOC_IFC_FLOW_STATUS);

        // Error responses
        apb_read('h40);
        apb_read('h3C);
        apb_write(`SOC_IFC_FLOW_STATUS, 32'h3);
        apb_read(`SOC_IFC_FLOW_STATUS);

        // Timer 1 with timer 2 running on its own
        apb_write(`SOC_IFC_WDT_T1_PERIOD, T1_PER);
        apb_read(`SOC_IFC_WDT_T1_PERIOD);
        apb_write(`SOC_IFC_WDT_T2_EN, 32'h1);
        apb_write(`SOC_IFC_WDT_T1_EN, 32'h1);
        t0 = cycles;
        poll_status(0, t0, T1_PER + MARGIN, "t1 timeout after enable");
        apb_write(`SOC_IFC_WDT_STATUS, 32'h1);
        apb_read(`SOC_IFC_WDT_STATUS);
        repeat (T1_PER * 3 / 4) @(posedge clk);
        apb_write(`SOC_IFC_WDT_T1_CTRL, 32'h1);
        t0 = cycles;
        repeat (T1_PER / 2) @(posedge clk);
        // Past the unrestarted expiry, so still clear only because of the restart
        apb_read(`SOC_IFC_WDT_STATUS);
        poll_status(0, t0, T1_PER + MARGIN, "t1 timeout after restart");
        apb_write(`SOC_IFC_WDT_T1_EN, 32'h0);
        apb_write(`SOC_IFC_WDT_STATUS, 32'h3);
        apb_read(`SOC_IFC_WDT_STATUS);

        // Cascaded mode
        apb_write(`SOC_IFC_WDT_T2_EN, 32'h0);
        apb_write(`SOC_IFC_WDT_T1_PERIOD, C1_PER);
        apb_write(`SOC_IFC_WDT_T2_PERIOD, C2_PER);
        check_val("nmi_intr_o", 32'(nmi_intr_o), 32'd0);
        apb_write(`SOC_IFC_WDT_T1_EN, 32'h1);
        wait_level("nmi_intr_o", 2, 1'b1, C1_PER + C2_PER + MARGIN);
        check_val("cptra_error_fatal_o", 32'(cptra_error_fatal_o), 32'd1);
        apb_write(`SOC_IFC_WDT_STATUS, 32'h3);
        wait_level("nmi_intr_o", 2, 1'b0, MARGIN);
        check_val("cptra_error_fatal_o", 32'(cptra_error_fatal_o), 32'd0);
        apb_write(`SOC_IFC_WDT_T1_EN, 32'h0);

        // Fresh boot with the breakpoint held
        apply_reset(1'b1);
        wait_level("ready_for_fuses_o", 0, 1'b1, MARGIN);
        apb_write(`SOC_IFC_FUSE_WR_DONE, 32'h1);
        repeat (2 * MARGIN) @(posedge clk);
        check_val("cptra_uc_rst_b_o", 32'(cptra_uc_rst_b_o), 32'd0);
        check_val("ready_for_fuses_o", 32'(ready_for_fuses_o), 32'd0);
        sh_flow = 2'b00;
        apb_read(`SOC_IFC_FLOW_STATUS);
        apb_write(`SOC_IFC_BOOTFSM_GO, 32'h1);
        wait_level("cptra_uc_rst_b_o", 1, 1'b1, MARGIN);
        sh_flow = 2'b10;
        apb_read(`SOC_IFC_FLOW_STATUS);
        apb_read(`SOC_IFC_BOOTFSM_GO);

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
src/soc_ifc_pkg.sv
src/soc_ifc_apb_slave.sv
src/soc_ifc_regs.sv
src/soc_ifc_boot_fsm.sv
src/soc_ifc_wdt.sv
src/soc_ifc_top.sv
bench/soc_ifc_assert.sv
bench/soc_ifc_tb.sv

//--- include/soc_ifc_consts.svh
`ifndef SOC_IFC_CONSTS_SVH
`define SOC_IFC_CONSTS_SVH

// Bus widths
`define SOC_IFC_ADDR_W 12
`define SOC_IFC_DATA_W 32

// Number of UDS fuse words
`define SOC_IFC_FUSE_WORDS 4

//////////////////////////////////////////////////
// Register byte offsets
//////////////////////////////////////////////////
`define SOC_IFC_FUSE_WR_DONE  'h00
`define SOC_IFC_FLOW_STATUS   'h04
`define SOC_IFC_BOOTFSM_GO    'h08
`define SOC_IFC_FUSE_UDS_BASE 'h10
`define SOC_IFC_WDT_T1_EN     'h20
`define SOC_IFC_WDT_T2_EN     'h24
`define SOC_IFC_WDT_T1_PERIOD 'h28
`define SOC_IFC_WDT_T2_PERIOD 'h2C
`define SOC_IFC_WDT_STATUS    'h30
`define SOC_IFC_WDT_T1_CTRL   'h34
`define SOC_IFC_WDT_T2_CTRL   'h38

// Both watchdog periods come out of reset at the maximum count
`define SOC_IFC_WDT_PERIOD_RST 'hFFFF_FFFF

`endif

//--- src/soc_ifc_apb_slave.sv
`include "soc_ifc_consts.svh"

module soc_ifc_apb_slave (
    input  logic                       clk,
    input  logic                       cptra_rst_b,
    input  logic [`SOC_IFC_ADDR_W-1:0] paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`SOC_IFC_DATA_W-1:0] pwdata_i,
    input  soc_ifc_pkg::reg_rsp_t      rsp_i,
    input  logic                       rsp_valid_i,
    output soc_ifc_pkg::reg_req_t      req_o,
    output logic                       req_valid_o,
    output logic [`SOC_IFC_DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o
);

    logic setup;
    logic complete;

    // Setup phase of a transfer
    assign setup = psel_i & ~penable_i;

    // Request pulse lands in the first access cycle
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= setup;
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            req_o.write <= pwrite_i;
            req_o.addr  <= paddr_i;
            req_o.wdata <= pwdata_i;
        end
    end

    //////////////////////////////////////////////////
    // Completion in the second access cycle
    //////////////////////////////////////////////////
    assign complete  = rsp_valid_i & psel_i & penable_i;
    assign pready_o  = complete;
    assign pslverr_o = complete & rsp_i.error;
    assign prdata_o  = complete ? rsp_i.rdata : '0;

endmodule

//--- src/soc_ifc_boot_fsm.sv
module soc_ifc_boot_fsm (
    input  logic                     clk,
    input  logic                     cptra_rst_b,
    input  logic                     bootfsm_brkpoint_i,
    input  logic                     fuse_done_i,
    input  logic                     bootfsm_go_i,
    output logic                     ready_for_fuses_o,
    output logic                     cptra_uc_rst_b_o,
    output soc_ifc_pkg::boot_state_e state_o
);

    soc_ifc_pkg::boot_state_e state_d;
    logic                     brkpt_q;

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////
    always_comb begin
        state_d = state_o;
        case (state_o)
            soc_ifc_pkg::RESET: state_d = soc_ifc_pkg::FUSE;
            soc_ifc_pkg::FUSE: begin
                if (fuse_done_i) begin
                    state_d = brkpt_q ? soc_ifc_pkg::BRKPT : soc_ifc_pkg::DONE;
                end
            end
            soc_ifc_pkg::BRKPT: begin
                // Hold the core until the SoC writes GO
                if (bootfsm_go_i) begin
                    state_d = soc_ifc_pkg::DONE;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_o          <= soc_ifc_pkg::RESET;
            brkpt_q          <= 1'b0;
            cptra_uc_rst_b_o <= 1'b0;
        end else begin
            state_o          <= state_d;
            cptra_uc_rst_b_o <= (state_d == soc_ifc_pkg::DONE);
            // Breakpoint sampled once, in the first cycle out of reset
            if (state_o == soc_ifc_pkg::RESET) begin
                brkpt_q <= bootfsm_brkpoint_i;
            end
        end
    end

    assign ready_for_fuses_o = (state_o == soc_ifc_pkg::FUSE);

endmodule

//--- src/soc_ifc_pkg.sv
`include "soc_ifc_consts.svh"

package soc_ifc_pkg;

    // One register access from the APB side
    typedef struct packed {
        logic                       write;
        logic [`SOC_IFC_ADDR_W-1:0] addr;
        logic [`SOC_IFC_DATA_W-1:0] wdata;
    } reg_req_t;

    // Completion of an access
    typedef struct packed {
        logic [`SOC_IFC_DATA_W-1:0] rdata;
        logic                       error;
    } reg_rsp_t;

    // Watchdog controls held in the register block
    typedef struct packed {
        logic                       t1_en;
        logic                       t2_en;
        logic                       t1_restart;
        logic                       t2_restart;
        logic                       t1_service;
        logic                       t2_service;
        logic [`SOC_IFC_DATA_W-1:0] t1_period;
        logic [`SOC_IFC_DATA_W-1:0] t2_period;
    } wdt_cfg_t;

    typedef struct packed {
        logic t1_timeout;
        logic t2_timeout;
    } wdt_status_t;

    // Boot sequencer states
    typedef enum logic [1:0] {
        RESET = 2'd0,
        FUSE  = 2'd1,
        BRKPT = 2'd2,
        DONE  = 2'd3
    } boot_state_e;

endpackage

//--- src/soc_ifc_regs.sv
`include "soc_ifc_consts.svh"

module soc_ifc_regs (
    input  logic                         clk,
    input  logic                         cptra_rst_b,
    input  soc_ifc_pkg::reg_req_t        req_i,
    input  logic                         req_valid_i,
    input  soc_ifc_pkg::wdt_status_t     wdt_status_i,
    input  logic                         ready_for_fuses_i,
    input  logic                         uc_released_i,
    output soc_ifc_pkg::reg_rsp_t        rsp_o,
    output logic                         rsp_valid_o,
    output soc_ifc_pkg::wdt_cfg_t        wdt_cfg_o,
    output logic                         fuse_done_o,
    output logic                         bootfsm_go_o,
    output logic [`SOC_IFC_FUSE_WORDS-1:0][`SOC_IFC_DATA_W-1:0] fuse_uds_o
);

    logic [31:0]                     addr;
    logic [`SOC_IFC_DATA_W-1:0]      rd_data;
    logic                            hit;
    logic                            flow_hit;
    logic [`SOC_IFC_FUSE_WORDS-1:0]  fuse_hit;
    logic                            rsp_err;
    logic                            wr_en;

    assign addr  = 32'(req_i.addr);
    assign wr_en = req_valid_i & req_i.write;

    //////////////////////////////////////////////////
    // Address decode and read mux
    //////////////////////////////////////////////////
    always_comb begin
        rd_data  = '0;
        hit      = 1'b1;
        flow_hit = 1'b0;
        fuse_hit = '0;
        case (addr)
            `SOC_IFC_FUSE_WR_DONE:  rd_data[0] = fuse_done_o;
            `SOC_IFC_FLOW_STATUS: begin
                rd_data[1:0] = {uc_released_i, ready_for_fuses_i};
                flow_hit     = 1'b1;
            end
            `SOC_IFC_BOOTFSM_GO:    rd_data[0] = bootfsm_go_o;
            `SOC_IFC_WDT_T1_EN:     rd_data[0] = wdt_cfg_o.t1_en;
            `SOC_IFC_WDT_T2_EN:     rd_data[0] = wdt_cfg_o.t2_en;
            `SOC_IFC_WDT_T1_PERIOD: rd_data = wdt_cfg_o.t1_period;
            `SOC_IFC_WDT_T2_PERIOD: rd_data = wdt_cfg_o.t2_period;
            `SOC_IFC_WDT_STATUS: begin
                rd_data[1:0] = {wdt_status_i.t2_timeout, wdt_status_i.t1_timeout};
            end
            // Restart controls always read back as zero
            `SOC_IFC_WDT_T1_CTRL, `SOC_IFC_WDT_T2_CTRL: rd_data = '0;
            default: hit = 1'b0;
        endcase
        for (int i = 0; i < `SOC_IFC_FUSE_WORDS; i++) begin
            if (addr == `SOC_IFC_FUSE_UDS_BASE + 4 * i) begin
                fuse_hit[i] = 1'b1;
                hit         = 1'b1;
                rd_data     = fuse_uds_o[i];
            end
        end
    end

    // Unmapped reads and writes to the flow status fail
    assign rsp_err = req_i.write ? flow_hit : ~hit;

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_done_o  <= 1'b0;
            bootfsm_go_o <= 1'b0;
            fuse_uds_o   <= '0;
            wdt_cfg_o    <= '{t1_period: `SOC_IFC_WDT_PERIOD_RST,
                              t2_period: `SOC_IFC_WDT_PERIOD_RST,
                              default: '0};
        end else begin
            // Pulses last one cycle
            wdt_cfg_o.t1_restart <= 1'b0;
            wdt_cfg_o.t2_restart <= 1'b0;
            wdt_cfg_o.t1_service <= 1'b0;
            wdt_cfg_o.t2_service <= 1'b0;
            if (wr_en) begin
                case (addr)
                    // Done is sticky until reset
                    `SOC_IFC_FUSE_WR_DONE:  fuse_done_o <= fuse_done_o | req_i.wdata[0];
                    `SOC_IFC_BOOTFSM_GO:    bootfsm_go_o <= req_i.wdata[0];
                    `SOC_IFC_WDT_T1_EN:     wdt_cfg_o.t1_en <= req_i.wdata[0];
                    `SOC_IFC_WDT_T2_EN:     wdt_cfg_o.t2_en <= req_i.wdata[0];
                    `SOC_IFC_WDT_T1_PERIOD: wdt_cfg_o.t1_period <= req_i.wdata;
                    `SOC_IFC_WDT_T2_PERIOD: wdt_cfg_o.t2_period <= req_i.wdata;
                    `SOC_IFC_WDT_STATUS: begin
                        wdt_cfg_o.t1_service <= req_i.wdata[0];
                        wdt_cfg_o.t2_service <= req_i.wdata[1];
                    end
                    `SOC_IFC_WDT_T1_CTRL:   wdt_cfg_o.t1_restart <= req_i.wdata[0];
                    `SOC_IFC_WDT_T2_CTRL:   wdt_cfg_o.t2_restart <= req_i.wdata[0];
                    default: ;
                endcase
                // Fuses lock once done is set
                for (int i = 0; i < `SOC_IFC_FUSE_WORDS; i++) begin
                    if (fuse_hit[i] && !fuse_done_o) begin
                        fuse_uds_o[i] <= req_i.wdata;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Response register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rsp_o.error <= rsp_err;
            rsp_o.rdata <= (req_i.write || rsp_err) ? '0 : rd_data;
        end
    end

endmodule

//--- src/soc_ifc_top.sv
`include "soc_ifc_consts.svh"

module soc_ifc_top (
    input  logic                       clk,
    input  logic                       cptra_rst_b,
    input  logic                       bootfsm_brkpoint_i,
    // APB target
    input  logic [`SOC_IFC_ADDR_W-1:0] paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [`SOC_IFC_DATA_W-1:0] pwdata_i,
    output logic [`SOC_IFC_DATA_W-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    // Boot and error outputs
    output logic                       ready_for_fuses_o,
    output logic                       cptra_uc_rst_b_o,
    output logic [`SOC_IFC_FUSE_WORDS-1:0][`SOC_IFC_DATA_W-1:0] fuse_uds_o,
    output logic                       nmi_intr_o,
    output logic                       cptra_error_fatal_o
);

    soc_ifc_pkg::reg_req_t    req;
    logic                     req_valid;
    soc_ifc_pkg::reg_rsp_t    rsp;
    logic                     rsp_valid;
    soc_ifc_pkg::wdt_cfg_t    wdt_cfg;
    soc_ifc_pkg::wdt_status_t wdt_status;
    logic                     fuse_done;
    logic                     bootfsm_go;
    soc_ifc_pkg::boot_state_e boot_state;

    soc_ifc_apb_slave i_apb_slave (
        .clk         (clk),
        .cptra_rst_b (cptra_rst_b),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .rsp_i       (rsp),
        .rsp_valid_i (rsp_valid),
        .req_o       (req),
        .req_valid_o (req_valid),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o)
    );

    soc_ifc_regs i_regs (
        .clk               (clk),
        .cptra_rst_b       (cptra_rst_b),
        .req_i             (req),
        .req_valid_i       (req_valid),
        .wdt_status_i      (wdt_status),
        .ready_for_fuses_i (ready_for_fuses_o),
        .uc_released_i     (cptra_uc_rst_b_o),
        .rsp_o             (rsp),
        .rsp_valid_o       (rsp_valid),
        .wdt_cfg_o         (wdt_cfg),
        .fuse_done_o       (fuse_done),
        .bootfsm_go_o      (bootfsm_go),
        .fuse_uds_o        (fuse_uds_o)
    );

    soc_ifc_boot_fsm i_boot_fsm (
        .clk                (clk),
        .cptra_rst_b        (cptra_rst_b),
        .bootfsm_brkpoint_i (bootfsm_brkpoint_i),
        .fuse_done_i        (fuse_done),
        .bootfsm_go_i       (bootfsm_go),
        .ready_for_fuses_o  (ready_for_fuses_o),
        .cptra_uc_rst_b_o   (cptra_uc_rst_b_o),
        .state_o            (boot_state)
    );

    soc_ifc_wdt i_wdt (
        .clk                 (clk),
        .cptra_rst_b         (cptra_rst_b),
        .cfg_i               (wdt_cfg),
        .status_o            (wdt_status),
        .nmi_intr_o          (nmi_intr_o),
        .cptra_error_fatal_o (cptra_error_fatal_o)
    );

endmodule

//--- src/soc_ifc_wdt.sv
`include "soc_ifc_consts.svh"

module soc_ifc_wdt (
    input  logic                     clk,
    input  logic                     cptra_rst_b,
    input  soc_ifc_pkg::wdt_cfg_t    cfg_i,
    output soc_ifc_pkg::wdt_status_t status_o,
    output logic                     nmi_intr_o,
    output logic                     cptra_error_fatal_o
);

    logic [1:0]                          run;
    logic [1:0]                          svc;
    logic [1:0]                          clr;
    logic [1:0][`SOC_IFC_DATA_W-1:0]     period;
    logic [1:0][`SOC_IFC_DATA_W-1:0]     cnt_q;
    logic [1:0]                          to_q;
    logic                                cascade_fire;

    // Timer 2 runs on its own enable or, when cascaded, behind a timer 1 timeout
    assign run[0] = cfg_i.t1_en;
    assign run[1] = cfg_i.t2_en | to_q[0];

    assign svc    = {cfg_i.t2_service, cfg_i.t1_service};
    assign period = {cfg_i.t2_period, cfg_i.t1_period};

    // Disable, restart or service all start the count over
    assign clr[0] = ~run[0] | cfg_i.t1_restart | svc[0];
    assign clr[1] = ~run[1] | cfg_i.t2_restart | svc[1];

    //////////////////////////////////////////////////
    // Counters and sticky timeout flags
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            cnt_q <= '0;
            to_q  <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_q[i] != period[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                if (svc[i]) begin
                    to_q[i] <= 1'b0;
                end else if (!clr[i] && cnt_q[i] == period[i]) begin
                    to_q[i] <= 1'b1;
                end
            end
        end
    end

    assign status_o.t1_timeout = to_q[0];
    assign status_o.t2_timeout = to_q[1];

    // Second stage expiry in cascaded mode is fatal
    assign cascade_fire        = to_q[1] & ~cfg_i.t2_en;
    assign nmi_intr_o          = cascade_fire;
    assign cptra_error_fatal_o = cascade_fire;

endmodule
